/* filelist.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/register_file.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/cpu_core.sv
tests/tb_clock.sv
tests/tb_cpu.sv

/* rtl/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// core dimensions
//////////////////////////////////////////////////////////////////////

// data and instruction width
`define CPU_WORD_SIZE 16

// architectural registers
`define CPU_NUM_REGS 4

// bits needed to name one register
`define CPU_REG_IDX_W 2

`endif

/* rtl/cpu_core.sv */
`default_nettype none

module cpu_core
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic  clk,
   input  logic  reset_n,
   output logic  o_i_req,
   output word_t o_i_addr,
   input  logic  i_i_ack,
   input  word_t i_i_data,
   output logic  o_out_valid,
   output word_t o_out_data,
   output logic  o_halted
);

   // fetch to decode
   logic       if_valid;
   word_t      if_inst;

   // register file ports
   reg_idx_t   raddr1;
   reg_idx_t   raddr2;
   word_t      rdata1;
   word_t      rdata2;
   logic       wb_we;
   reg_idx_t   wb_waddr;
   word_t      wb_wdata;

   // ID/EX
   reg_idx_t   ex_rs;
   reg_idx_t   ex_rt;
   reg_idx_t   ex_dst;
   word_t      ex_a;
   word_t      ex_b;
   word_t      ex_imm;
   alu_op_t    ex_alu_op;
   alu_src_b_t ex_src_b;
   wb_src_t    ex_wb_src;
   logic       ex_we;
   logic       ex_wwd;
   logic       ex_halt;

   //////////////////////////////////////////////////////////////////////
   // stages
   //////////////////////////////////////////////////////////////////////

   fetch_unit u_fetch (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_i_ack     (i_i_ack),
      .i_i_data    (i_i_data),
      .i_halt_seen (o_halted),
      .o_i_req     (o_i_req),
      .o_i_addr    (o_i_addr),
      .o_if_valid  (if_valid),
      .o_if_inst   (if_inst)
   );

   decode_unit u_decode (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_if_valid (if_valid),
      .i_if_inst  (if_inst),
      .i_rdata1   (rdata1),
      .i_rdata2   (rdata2),
      .o_raddr1   (raddr1),
      .o_raddr2   (raddr2),
      .o_rs       (ex_rs),
      .o_rt       (ex_rt),
      .o_dst      (ex_dst),
      .o_a        (ex_a),
      .o_b        (ex_b),
      .o_imm      (ex_imm),
      .o_alu_op   (ex_alu_op),
      .o_src_b    (ex_src_b),
      .o_wb_src   (ex_wb_src),
      .o_we       (ex_we),
      .o_wwd      (ex_wwd),
      .o_halt     (ex_halt)
   );

   // written from the EX/WB register
   register_file u_rf (
      .clk      (clk),
      .reset_n  (reset_n),
      .i_raddr1 (raddr1),
      .i_raddr2 (raddr2),
      .i_we     (wb_we),
      .i_waddr  (wb_waddr),
      .i_wdata  (wb_wdata),
      .o_rdata1 (rdata1),
      .o_rdata2 (rdata2)
   );

   execute_unit u_execute (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_rs        (ex_rs),
      .i_rt        (ex_rt),
      .i_dst       (ex_dst),
      .i_a         (ex_a),
      .i_b         (ex_b),
      .i_imm       (ex_imm),
      .i_alu_op    (ex_alu_op),
      .i_src_b     (ex_src_b),
      .i_wb_src    (ex_wb_src),
      .i_we        (ex_we),
      .i_wwd       (ex_wwd),
      .i_halt      (ex_halt),
      .o_we        (wb_we),
      .o_waddr     (wb_waddr),
      .o_wdata     (wb_wdata),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data),
      .o_halted    (o_halted)
   );

endmodule

`default_nettype wire

/* rtl/decode_unit.sv */
`default_nettype none

module decode_unit
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  logic       i_if_valid,
   input  word_t      i_if_inst,
   input  word_t      i_rdata1,
   input  word_t      i_rdata2,
   output reg_idx_t   o_raddr1,
   output reg_idx_t   o_raddr2,
   output reg_idx_t   o_rs,
   output reg_idx_t   o_rt,
   output reg_idx_t   o_dst,
   output word_t      o_a,
   output word_t      o_b,
   output word_t      o_imm,
   output alu_op_t    o_alu_op,
   output alu_src_b_t o_src_b,
   output wb_src_t    o_wb_src,
   output logic       o_we,
   output logic       o_wwd,
   output logic       o_halt
);

   opcode_t    opcode;
   func_t      func;
   reg_idx_t   rs;
   reg_idx_t   rt;
   imm8_t      imm8;
   reg_idx_t   dst;
   word_t      imm;
   alu_op_t    alu_op;
   alu_src_b_t src_b;
   wb_src_t    wb_src;
   logic       we;
   logic       wwd;
   logic       halt;

   assign opcode = inst_opcode(i_if_inst);
   assign func   = inst_func(i_if_inst);
   assign rs     = inst_rs(i_if_inst);
   assign rt     = inst_rt(i_if_inst);
   assign imm8   = inst_imm8(i_if_inst);

   // rs and rt always read, whether used or not
   assign o_raddr1 = rs;
   assign o_raddr2 = rt;

   //////////////////////////////////////////////////////////////////////
   // control decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      // defaults give a bubble
      alu_op = ALU_ADD;
      src_b  = SRC_B_REG;
      wb_src = WB_ALU;
      we     = 1'b0;
      wwd    = 1'b0;
      halt   = 1'b0;
      dst    = inst_rd(i_if_inst);
      // sign-extended
      imm    = word_t'(signed'(imm8));
      case (opcode)
         OP_RTYPE: begin
            we = 1'b1;
            case (func)
               FUNC_ADD: alu_op = ALU_ADD;
               FUNC_SUB: alu_op = ALU_SUB;
               FUNC_AND: alu_op = ALU_AND;
               FUNC_ORR: alu_op = ALU_OR;
               FUNC_NOT: alu_op = ALU_NOT;
               FUNC_TCP: alu_op = ALU_TCP;
               FUNC_SHL: alu_op = ALU_SHL;
               FUNC_SHR: alu_op = ALU_SHR;
               FUNC_WWD: begin
                  we  = 1'b0;
                  wwd = 1'b1;
               end
               FUNC_HLT: begin
                  we   = 1'b0;
                  halt = 1'b1;
               end
               default: we = 1'b0;
            endcase
         end
         OP_ADI: begin
            we    = 1'b1;
            dst   = rt;
            src_b = SRC_B_IMM;
         end
         OP_ORI: begin
            we     = 1'b1;
            dst    = rt;
            src_b  = SRC_B_IMM;
            alu_op = ALU_OR;
            imm    = word_t'(imm8);
         end
         OP_LHI: begin
            we     = 1'b1;
            dst    = rt;
            wb_src = WB_IMM_HI;
            imm    = word_t'(imm8);
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // ID/EX register
   //////////////////////////////////////////////////////////////////////

   // controls, zeroed when no word arrived
   always_ff @(posedge clk) begin
      if (!reset_n || !i_if_valid) begin
         o_alu_op <= ALU_ADD;
         o_src_b  <= SRC_B_REG;
         o_wb_src <= WB_ALU;
         o_we     <= 1'b0;
         o_wwd    <= 1'b0;
         o_halt   <= 1'b0;
      end else begin
         o_alu_op <= alu_op;
         o_src_b  <= src_b;
         o_wb_src <= wb_src;
         o_we     <= we;
         o_wwd    <= wwd;
         o_halt   <= halt;
      end
   end

   // operands and indices
   always_ff @(posedge clk) begin
      o_rs  <= rs;
      o_rt  <= rt;
      o_dst <= dst;
      o_a   <= i_rdata1;
      o_b   <= i_rdata2;
      o_imm <= imm;
   end

   // a wwd writes the port, never a register
   a_we_wwd_excl : assert property (@(posedge clk) disable iff (!reset_n)
      !(o_we && o_wwd));

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`default_nettype none

module execute_unit
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  reg_idx_t   i_rs,
   input  reg_idx_t   i_rt,
   input  reg_idx_t   i_dst,
   input  word_t      i_a,
   input  word_t      i_b,
   input  word_t      i_imm,
   input  alu_op_t    i_alu_op,
   input  alu_src_b_t i_src_b,
   input  wb_src_t    i_wb_src,
   input  logic       i_we,
   input  logic       i_wwd,
   input  logic       i_halt,
   output logic       o_we,
   output reg_idx_t   o_waddr,
   output word_t      o_wdata,
   output logic       o_out_valid,
   output word_t      o_out_data,
   output logic       o_halted
);

   word_t   a_fwd;
   word_t   b_fwd;
   word_t   op_b;
   word_t   alu_result;
   word_t   lhi_value;
   word_t   alu_out_wb;
   word_t   imm_hi_wb;
   wb_src_t wb_src_wb;

   //////////////////////////////////////////////////////////////////////
   // forwarding from WB
   //////////////////////////////////////////////////////////////////////

   // distance one; distance two is covered by the rf write-through
   assign a_fwd = (o_we && (o_waddr == i_rs)) ? o_wdata : i_a;
   assign b_fwd = (o_we && (o_waddr == i_rt)) ? o_wdata : i_b;

   assign op_b = (i_src_b == SRC_B_IMM) ? i_imm : b_fwd;

   //////////////////////////////////////////////////////////////////////
   // alu
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (i_alu_op)
         ALU_ADD: alu_result = a_fwd + op_b;
         ALU_SUB: alu_result = a_fwd - op_b;
         ALU_AND: alu_result = a_fwd & op_b;
         ALU_OR:  alu_result = a_fwd | op_b;
         ALU_NOT: alu_result = ~a_fwd;
         // two's complement negate
         ALU_TCP: alu_result = ~a_fwd + 1'b1;
         ALU_SHL: alu_result = a_fwd << 1;
         // arithmetic, sign bit kept
         ALU_SHR: alu_result = word_t'($signed(a_fwd) >>> 1);
         default: alu_result = '0;
      endcase
   end

   // lhi, immediate into the upper half
   assign lhi_value = i_imm << ($bits(word_t) / 2);

   //////////////////////////////////////////////////////////////////////
   // EX/WB register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_we        <= 1'b0;
         wb_src_wb   <= WB_ALU;
         o_out_valid <= 1'b0;
         o_out_data  <= '0;
         o_halted    <= 1'b0;
      end else begin
         o_we        <= i_we;
         wb_src_wb   <= i_wb_src;
         // output port pulse for wwd
         o_out_valid <= i_wwd;
         if (i_wwd) begin
            o_out_data <= a_fwd;
         end
         // sticky until reset
         if (i_halt) begin
            o_halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      o_waddr    <= i_dst;
      alu_out_wb <= alu_result;
      imm_hi_wb  <= lhi_value;
   end

   // writeback value, also the forwarding source
   assign o_wdata = (wb_src_wb == WB_IMM_HI) ? imm_hi_wb : alu_out_wb;

   // halt is only cleared by reset
   a_halt_sticky : assert property (@(posedge clk) disable iff (!reset_n)
      o_halted |=> o_halted);

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`default_nettype none

module fetch_unit
   import isa_pkg::*;
(
   input  logic  clk,
   input  logic  reset_n,
   input  logic  i_i_ack,
   input  word_t i_i_data,
   input  logic  i_halt_seen,
   output logic  o_i_req,
   output word_t o_i_addr,
   output logic  o_if_valid,
   output word_t o_if_inst
);

   // idle only for the first cycle out of reset
   typedef enum logic [1:0] {
      F_IDLE,
      F_REQ,
      F_DROP,
      F_HALT
   } fetch_state_t;

   fetch_state_t state;
   word_t        pc;
   word_t        ir;
   logic         if_valid;
   logic         accept;
   logic         hlt_word;

   // word taken on the first ack seen while requesting
   assign accept = (state == F_REQ) && i_i_ack;

   // halt recognised straight off the bus
   assign hlt_word = (inst_opcode(i_i_data) == OP_RTYPE) &&
                     (inst_func(i_i_data) == FUNC_HLT);

   //////////////////////////////////////////////////////////////////////
   // four-phase handshake FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state    <= F_IDLE;
         pc       <= '0;
         if_valid <= 1'b0;
      end else begin
         // valid is a single-cycle pulse
         if_valid <= accept;
         case (state)
            F_IDLE: begin
               state <= F_REQ;
            end
            F_REQ: begin
               if (i_i_ack) begin
                  pc    <= pc + 1'b1;
                  state <= hlt_word ? F_HALT : F_DROP;
               end
            end
            F_DROP: begin
               // wait for memory to release ack
               if (!i_i_ack) begin
                  state <= F_REQ;
               end
            end
            default: begin
               // halted until reset
               state <= F_HALT;
            end
         endcase
      end
   end

   // instruction register
   always_ff @(posedge clk) begin
      if (accept) begin
         ir <= i_i_data;
      end
   end

   assign o_i_req    = (state == F_REQ);
   assign o_i_addr   = pc;
   assign o_if_valid = if_valid;
   assign o_if_inst  = ir;

   // req held until the memory answers
   a_req_hold : assert property (@(posedge clk) disable iff (!reset_n)
      o_i_req && !i_i_ack |=> o_i_req);

   // address must not move under a pending request
   a_addr_stable : assert property (@(posedge clk) disable iff (!reset_n)
      o_i_req && !i_i_ack |=> $stable(o_i_addr));

   // once execute reports halt, fetch has already gone quiet
   a_no_req_halted : assert property (@(posedge clk) disable iff (!reset_n)
      i_halt_seen |-> !o_i_req);

endmodule

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

`include "cpu_config.svh"

package isa_pkg;

   // machine word and register number
   typedef logic [`CPU_WORD_SIZE-1:0] word_t;
   typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

   // low byte immediate field
   typedef logic [7:0] imm8_t;

   //////////////////////////////////////////////////////////////////////
   // opcode and function code encodings
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      OP_ADI   = 4'd4,
      OP_ORI   = 4'd5,
      OP_LHI   = 4'd6,
      OP_RTYPE = 4'd15
   } opcode_t;

   // only meaningful when opcode is OP_RTYPE
   typedef enum logic [5:0] {
      FUNC_ADD = 6'd0,
      FUNC_SUB = 6'd1,
      FUNC_AND = 6'd2,
      FUNC_ORR = 6'd3,
      FUNC_NOT = 6'd4,
      FUNC_TCP = 6'd5,
      FUNC_SHL = 6'd6,
      FUNC_SHR = 6'd7,
      FUNC_WWD = 6'd28,
      FUNC_HLT = 6'd29
   } func_t;

   //////////////////////////////////////////////////////////////////////
   // field extraction
   //////////////////////////////////////////////////////////////////////

   function automatic opcode_t inst_opcode(word_t inst);
      return opcode_t'(inst[15:12]);
   endfunction

   function automatic func_t inst_func(word_t inst);
      return func_t'(inst[5:0]);
   endfunction

   // rs at 11:10, rt at 9:8, rd at 7:6
   function automatic reg_idx_t inst_rs(word_t inst);
      return inst[11:10];
   endfunction

   function automatic reg_idx_t inst_rt(word_t inst);
      return inst[9:8];
   endfunction

   function automatic reg_idx_t inst_rd(word_t inst);
      return inst[7:6];
   endfunction

   // overlaps rd and func
   function automatic imm8_t inst_imm8(word_t inst);
      return inst[7:0];
   endfunction

endpackage

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

   //////////////////////////////////////////////////////////////////////
   // execute stage controls
   //////////////////////////////////////////////////////////////////////

   // alu function, one per r-type arithmetic op
   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_NOT = 4'd4,
      ALU_TCP = 4'd5,
      ALU_SHL = 4'd6,
      ALU_SHR = 4'd7
   } alu_op_t;

   // second alu operand
   typedef enum logic {
      SRC_B_REG = 1'b0,
      SRC_B_IMM = 1'b1
   } alu_src_b_t;

   //////////////////////////////////////////////////////////////////////
   // writeback controls
   //////////////////////////////////////////////////////////////////////

   // imm_hi is the lhi path
   typedef enum logic {
      WB_ALU    = 1'b0,
      WB_IMM_HI = 1'b1
   } wb_src_t;

endpackage

`default_nettype wire

/* rtl/register_file.sv */
`default_nettype none

`include "cpu_config.svh"

module register_file
   import isa_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   input  reg_idx_t i_raddr1,
   input  reg_idx_t i_raddr2,
   input  logic     i_we,
   input  reg_idx_t i_waddr,
   input  word_t    i_wdata,
   output word_t    o_rdata1,
   output word_t    o_rdata2
);

   word_t regs [`CPU_NUM_REGS];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // write-through, a read of the slot being written sees new data
   assign o_rdata1 = (i_we && (i_waddr == i_raddr1)) ? i_wdata : regs[i_raddr1];
   assign o_rdata2 = (i_we && (i_waddr == i_raddr2)) ? i_wdata : regs[i_raddr2];

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock #(
   parameter int HALF_PERIOD = 5
) (
   output logic o_clk
);

   // low at time zero, first rising edge after one half period
   initial begin
      o_clk = 1'b0;
   end

   // free-running, period 2 * HALF_PERIOD
   always begin
      #HALF_PERIOD o_clk = ~o_clk;
   end

endmodule

`default_nettype wire

/* tests/tb_cpu.sv */
`default_nettype none

module tb_cpu
   import isa_pkg::*;
;

   localparam int RESET_CYCLES = 8;
   // per-wait limits in cycles
   localparam int REQ_WAIT     = 40;
   localparam int DROP_WAIT    = 8;
   localparam int HALT_WAIT    = 1000;
   localparam int QUIET_CYCLES = 20;

   logic  clk;
   logic  reset_n;
   logic  o_i_req;
   word_t o_i_addr;
   logic  i_i_ack;
   word_t i_i_data;
   logic  o_out_valid;
   word_t o_out_data;
   logic  o_halted;

   // program table with one slot per instruction word
   word_t prog_inst [$];
   logic  prog_wwd [$];
   // expected port values in WWD order
   word_t exp_out [$];
   // cycle at which each WWD pulse is due
   int    out_cyc [$];

   int mismatch_count = 0;
   int timeout_count  = 0;
   int fail_count     = 0;
   int cyc            = 0;
   int out_count      = 0;
   int served         = 0;
   int halt_due       = -1;
   int out_due;

   tb_clock u_clock (
      .o_clk (clk)
   );

   cpu_core uut (
      .clk         (clk),
      .reset_n     (reset_n),
      .o_i_req     (o_i_req),
      .o_i_addr    (o_i_addr),
      .i_i_ack     (i_i_ack),
      .i_i_data    (i_i_data),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data),
      .o_halted    (o_halted)
   );

   // cycle count sampled on falling edges
   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   //////////////////////////////////////////////////////////////////////
   // result checks
   //////////////////////////////////////////////////////////////////////

   task automatic check_word(string name, word_t got, word_t exp);
      if (got !== exp) begin
         mismatch_count++;
         $display("MISMATCH %s: got 0x%04h expected 0x%04h", name, got, exp);
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         mismatch_count++;
         $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic flag_failure(string msg);
      fail_count++;
      $display("ERROR: %s", msg);
   endtask

   task automatic log_timeout(string what);
      timeout_count++;
      $display("TIMEOUT: %s", what);
   endtask

   //////////////////////////////////////////////////////////////////////
   // program table
   //////////////////////////////////////////////////////////////////////

   // r-type word from opcode, rs, rt, rd and func
   function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, func_t f);
      return {OP_RTYPE, rs, rt, rd, f};
   endfunction

   // i-type word from opcode, rs, rt and imm8
   function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm8_t imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic add_op(word_t inst);
      prog_inst.push_back(inst);
      prog_wwd.push_back(1'b0);
   endtask

   task automatic add_wwd(reg_idx_t rs, word_t exp);
      prog_inst.push_back(enc_r(rs, 2'd0, 2'd0, FUNC_WWD));
      prog_wwd.push_back(1'b1);
      exp_out.push_back(exp);
   endtask

   task automatic load_program();
      // constant built by lhi then a zero-extended ori
      add_op(enc_i(OP_LHI, 2'd0, 2'd1, 8'h12));
      add_op(enc_i(OP_ORI, 2'd1, 2'd1, 8'h34));
      add_wwd(2'd1, 16'h1234);
      // negative adi is sign extended
      add_op(enc_i(OP_ADI, 2'd0, 2'd2, 8'hfb));
      add_wwd(2'd2, 16'hfffb);
      add_op(enc_i(OP_ORI, 2'd0, 2'd3, 8'hf0));
      add_wwd(2'd3, 16'h00f0);
      add_op(enc_i(OP_ADI, 2'd3, 2'd3, 8'h7f));
      add_wwd(2'd3, 16'h016f);
      // r-type ops on r1 = 0x1234 and r2 = 0xfffb
      add_op(enc_r(2'd1, 2'd2, 2'd3, FUNC_ADD));
      add_wwd(2'd3, 16'h122f);
      add_op(enc_r(2'd1, 2'd2, 2'd3, FUNC_SUB));
      add_wwd(2'd3, 16'h1239);
      add_op(enc_r(2'd1, 2'd2, 2'd3, FUNC_AND));
      add_wwd(2'd3, 16'h1230);
      add_op(enc_r(2'd1, 2'd2, 2'd3, FUNC_ORR));
      add_wwd(2'd3, 16'hffff);
      add_op(enc_r(2'd1, 2'd0, 2'd3, FUNC_NOT));
      add_wwd(2'd3, 16'hedcb);
      add_op(enc_r(2'd1, 2'd0, 2'd3, FUNC_TCP));
      add_wwd(2'd3, 16'hedcc);
      add_op(enc_r(2'd1, 2'd0, 2'd3, FUNC_SHL));
      add_wwd(2'd3, 16'h2468);
      add_op(enc_r(2'd1, 2'd0, 2'd3, FUNC_SHR));
      add_wwd(2'd3, 16'h091a);
      // arithmetic shift keeps the sign
      add_op(enc_r(2'd2, 2'd0, 2'd3, FUNC_SHR));
      add_wwd(2'd3, 16'hfffd);
      // chain at distance one
      add_op(enc_i(OP_ADI, 2'd0, 2'd1, 8'h03));
      add_op(enc_r(2'd1, 2'd1, 2'd2, FUNC_ADD));
      add_op(enc_r(2'd2, 2'd0, 2'd3, FUNC_SHL));
      add_op(enc_r(2'd3, 2'd2, 2'd1, FUNC_SUB));
      add_wwd(2'd1, 16'h0006);
      // mixed distances one and two
      add_op(enc_i(OP_ORI, 2'd0, 2'd2, 8'h21));
      add_op(enc_i(OP_ADI, 2'd0, 2'd3, 8'h01));
      add_op(enc_r(2'd2, 2'd3, 2'd1, FUNC_ADD));
      add_op(enc_i(OP_LHI, 2'd0, 2'd0, 8'h80));
      add_op(enc_r(2'd1, 2'd1, 2'd2, FUNC_ADD));
      add_wwd(2'd0, 16'h8000);
      add_wwd(2'd2, 16'h0044);
      add_op(enc_r(2'd0, 2'd2, 2'd3, FUNC_ORR));
      add_wwd(2'd3, 16'h8044);
      // lhi straight into wwd and then an adi of -128
      add_op(enc_i(OP_LHI, 2'd0, 2'd1, 8'h5a));
      add_wwd(2'd1, 16'h5a00);
      add_op(enc_i(OP_ADI, 2'd1, 2'd1, 8'h80));
      add_wwd(2'd1, 16'h5980);
      // last word with nothing fetched after it
      add_op(enc_r(2'd0, 2'd0, 2'd0, FUNC_HLT));
   endtask

   //////////////////////////////////////////////////////////////////////
   // instruction memory responder
   //////////////////////////////////////////////////////////////////////

   initial begin
      int n;
      int unsigned delay;
      int unsigned seed_ret;
      logic alive;
      // one seed for every ack delay drawn below
      seed_ret = $urandom(52538);
      alive = 1'b1;
      @(negedge clk);
      for (int i = 0; i < prog_inst.size() && alive; i++) begin
         n = 0;
         while (!o_i_req && n < REQ_WAIT) begin
            @(negedge clk);
            n++;
         end
         if (!o_i_req) begin
            log_timeout($sformatf("no fetch request for table entry %0d", i));
            alive = 1'b0;
         end else begin
            // strict fetch order puts entry i at address i
            check_word("o_i_addr", o_i_addr, word_t'(i));
            delay = $urandom % 4;
            repeat (delay) begin
               @(negedge clk);
               check_flag("o_i_req", o_i_req, 1'b1);
               check_word("o_i_addr", o_i_addr, word_t'(i));
            end
            i_i_ack  = 1'b1;
            i_i_data = prog_inst[i];
            // ack sampled on the next edge and output two edges later
            if (prog_wwd[i]) begin
               out_cyc.push_back(cyc + 3);
            end
            if (i == prog_inst.size() - 1) begin
               halt_due = cyc + 3;
            end
            n = 0;
            while (o_i_req && n < DROP_WAIT) begin
               @(negedge clk);
               n++;
            end
            if (o_i_req) begin
               log_timeout($sformatf("request for entry %0d never dropped", i));
               alive = 1'b0;
            end
            i_i_ack  = 1'b0;
            i_i_data = '0;
            served++;
         end
      end
   end

   // one output pulse per WWD in order and on time
   always @(negedge clk) begin
      if (reset_n && o_out_valid) begin
         if (out_count < exp_out.size()) begin
            check_word("o_out_data", o_out_data, exp_out[out_count]);
            if (out_cyc.size() > 0) begin
               out_due = out_cyc.pop_front();
               if (cyc != out_due) begin
                  flag_failure($sformatf("output pulse %0d at cycle %0d, due at cycle %0d",
                                         out_count, cyc, out_due));
               end
            end else begin
               flag_failure("output pulse before its WWD was fetched");
            end
         end else begin
            flag_failure("output pulse with no WWD left in the program");
         end
         out_count++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int n;
      reset_n  = 1'b0;
      i_i_ack  = 1'b0;
      i_i_data = '0;
      load_program();
      // outputs quiet all through reset
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_flag("o_out_valid", o_out_valid, 1'b0);
         check_flag("o_halted", o_halted, 1'b0);
         check_word("o_out_data", o_out_data, '0);
         check_flag("o_i_req", o_i_req, 1'b0);
      end
      reset_n = 1'b1;
      // one idle cycle before the first fetch from 0
      @(negedge clk);
      check_flag("o_i_req", o_i_req, 1'b1);
      check_word("o_i_addr", o_i_addr, '0);
      check_flag("o_out_valid", o_out_valid, 1'b0);
      check_word("o_out_data", o_out_data, '0);
      n = 0;
      while (!o_halted && n < HALT_WAIT) begin
         @(negedge clk);
         n++;
      end
      if (!o_halted) begin
         log_timeout("core never raised o_halted");
      end else begin
         if (cyc != halt_due) begin
            flag_failure($sformatf("o_halted rose at cycle %0d, due at cycle %0d",
                                   cyc, halt_due));
         end
         // halted stays up while fetch and port stay silent
         repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_flag("o_halted", o_halted, 1'b1);
            check_flag("o_i_req", o_i_req, 1'b0);
            check_flag("o_out_valid", o_out_valid, 1'b0);
         end
      end
      if (out_count != exp_out.size()) begin
         flag_failure($sformatf("%0d output pulses seen, %0d WWDs in the program",
                                out_count, exp_out.size()));
      end
      if (served != prog_inst.size()) begin
         flag_failure($sformatf("%0d words fetched, %0d in the program",
                                served, prog_inst.size()));
      end
      $display("errors: %0d mismatches, %0d timeouts, %0d other",
               mismatch_count, timeout_count, fail_count);
      if (mismatch_count + timeout_count + fail_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire
